// ==== Makefile ====
SIM = obj_dir/VrvPredecTb

.PHONY: all run clean

all: run

$(SIM): rvPredec.f hdl/rvPredec_params.svh hdl/rvPredecPkg.sv hdl/rvParcelAlign.sv \
        hdl/rvPredecClass.sv hdl/rvRasHint.sv hdl/rvPredecTop.sv \
        verification/rvPredecChecker.sv verification/rvPredecTb.sv
	verilator --binary --timing --top-module rvPredecTb -f rvPredec.f -o VrvPredecTb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/rvParcelAlign.sv ====
module rvParcelAlign (
  input  logic        clk,
  input  logic        rst,
  input  logic        flush,
  input  logic [31:0] fetchWord,
  input  logic        fetchValid,
  output logic        fetchHold,
  output logic [31:0] instr,
  output logic        instrValid,
  output logic        isCompressed,
  output logic        pos0
);

  // Parcel buffer. The oldest halfword sits in the low bits, and unused
  // slots stay zero so the incoming word can be ORed in behind the rest.
  logic [47:0] bufHw;
  logic [2:0]  bufLo;    // Set where the halfword was the low half of its word.
  logic [1:0]  bufCnt;

  logic        take;
  logic [79:0] combHw;
  logic [4:0]  combLo;
  logic [2:0]  combCnt;
  logic        emitC;
  logic        emitF;
  logic [1:0]  useCnt;
  logic [79:0] restHw;
  logic [4:0]  restLo;
  logic [2:0]  restCnt;
  logic        restWhole;

  // The word is consumed only when the buffer has room for it.
  assign take = fetchValid && !fetchHold && !flush;

  // ~~~~~~~~~~~~~~~~~~~ Merge buffer and word ~~~~~~~~~~~~~~~~~~~
  always_comb begin : mergeWord
    combHw  = {32'd0, bufHw};
    combLo  = {2'b00, bufLo};
    combCnt = {1'b0, bufCnt};
    if (take) begin
      combHw  = combHw | ({48'd0, fetchWord} << {bufCnt, 4'b0000});
      combLo  = combLo | (5'b00001 << bufCnt);   // Low half first, then high half.
      combCnt = combCnt + 3'd2;
    end
  end

  // ~~~~~~~~~~~~~~~~~~ Extract oldest instruction ~~~~~~~~~~~~~~~~~~
  // Bits 1..0 of the first parcel give the length.
  assign emitC  = (combCnt != 3'd0) && (combHw[1:0] != 2'b11);
  assign emitF  = (combCnt >= 3'd2) && (combHw[1:0] == 2'b11);
  assign useCnt = emitC ? 2'd1 : (emitF ? 2'd2 : 2'd0);

  assign restHw  = combHw >> {useCnt, 4'b0000};
  assign restLo  = combLo >> useCnt;
  assign restCnt = combCnt - {1'b0, useCnt};

  // A whole instruction left behind means next cycle can emit without a new word.
  assign restWhole = (restCnt >= 3'd2) ||
                     ((restCnt == 3'd1) && (restHw[1:0] != 2'b11));

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      bufHw      <= '0;
      bufLo      <= '0;
      bufCnt     <= '0;
      fetchHold  <= 1'b0;
      instrValid <= 1'b0;
    end else begin
      bufHw      <= restHw[47:0];
      bufLo      <= restLo[2:0];
      bufCnt     <= restCnt[1:0];
      fetchHold  <= restWhole;
      instrValid <= emitC || emitF;
    end
  end

  always_ff @(posedge clk) begin
    if (emitC || emitF) begin
      instr        <= emitC ? {16'd0, combHw[15:0]} : combHw[31:0];
      isCompressed <= emitC;
      pos0         <= combLo[0];   // Where the first parcel came from.
    end
  end

endmodule

// ==== hdl/rvPredecClass.sv ====
`include "rvPredec_params.svh"

module rvPredecClass (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush,
  input  logic [31:0]             instr,
  input  logic                    instrValid,
  input  logic                    isCompressed,
  input  logic                    pos0,
  output logic                    clsValid,
  output logic [`RVP_CLASS_W-1:0] clsVec,
  output logic                    isLnk,
  output logic                    isRet,
  output rvPredecPkg::lnkE        lnk2,
  output logic [31:0]             instrOut
);
  import rvPredecPkg::*;

  logic [`RVP_CLASS_W-1:0] cVec;
  logic [`RVP_CLASS_W-1:0] fVec;
  logic [`RVP_CLASS_W-1:0] baseVec;
  logic [`RVP_CLASS_W-1:0] nextVec;
  logic                    cLnk;
  logic                    cRet;
  logic                    fLnk;
  logic                    fRet;
  logic                    nextLnk;
  logic                    nextRet;

  logic [1:0] quad;
  logic [2:0] cFunct3;
  logic [4:0] cRd;     // Also rs1 for c.jr and c.jalr.
  logic [4:0] cRs2;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic [4:0] rs1;

  // x1 and x5 are the link registers.
  function automatic logic isLinkReg(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  assign quad    = instr[1:0];
  assign cFunct3 = instr[15:13];
  assign cRd     = instr[11:7];
  assign cRs2    = instr[6:2];
  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rd      = instr[11:7];
  assign rs1     = instr[19:15];

  // ~~~~~~~~~~~~~~~~~~ Compressed quadrants ~~~~~~~~~~~~~~~~~~
  always_comb begin : compressedDecode
    cVec = '0;
    cLnk = 1'b0;
    cRet = 1'b0;
    case (quad)
      2'b00: begin
        case (cFunct3)
          3'b000: cVec[ClsAlu] = (instr[12:5] != 8'd0);   // c.addi4spn.
          3'b001: begin
            cVec[ClsLoad]    = 1'b1;
            cVec[ClsLoadFpu] = 1'b1;
          end
          3'b010, 3'b011: cVec[ClsLoad] = 1'b1;
          3'b101, 3'b110, 3'b111: cVec[ClsStore] = 1'b1;
          default: ;
        endcase
      end
      2'b01: begin
        case (cFunct3)
          3'b100: begin
            if (!instr[11]) cVec[ClsShift] = 1'b1;   // c.srli and c.srai.
            else cVec[ClsAlu] = 1'b1;
          end
          3'b101, 3'b110, 3'b111: cVec[ClsJump] = 1'b1;
          default: cVec[ClsAlu] = 1'b1;
        endcase
      end
      2'b10: begin
        case (cFunct3)
          3'b000: cVec[ClsShift] = 1'b1;
          3'b001: begin
            cVec[ClsLoad]    = 1'b1;
            cVec[ClsLoadFpu] = 1'b1;
          end
          3'b010, 3'b011: cVec[ClsLoad] = 1'b1;
          3'b100: begin
            if (cRs2 != 5'd0) begin
              cVec[ClsAlu] = 1'b1;   // c.mv and c.add.
            end else if (!instr[12]) begin
              if (cRd != 5'd0) begin
                cVec[ClsJump]  = 1'b1;
                cVec[ClsIndir] = 1'b1;
                cRet           = isLinkReg(cRd);
              end
            end else if (cRd == 5'd0) begin
              cVec[ClsSys] = 1'b1;   // c.ebreak.
            end else begin
              cVec[ClsJump]  = 1'b1;
              cVec[ClsIndir] = 1'b1;
              cLnk           = 1'b1;
            end
          end
          default: cVec[ClsStore] = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~ 32-bit major opcodes ~~~~~~~~~~~~~~~~~~~
  always_comb begin : fullDecode
    fVec = '0;
    fLnk = 1'b0;
    fRet = 1'b0;
    case (opcode)
      OpLoad: fVec[ClsLoad] = 1'b1;
      OpLoadFp: begin
        fVec[ClsLoad]    = 1'b1;
        fVec[ClsLoadFpu] = 1'b1;
      end
      OpStore, OpStoreFp: fVec[ClsStore] = 1'b1;
      OpImm, OpImm32: begin
        if (funct3 == 3'b001 || funct3 == 3'b101) fVec[ClsShift] = 1'b1;
        else fVec[ClsAlu] = 1'b1;
      end
      OpOp, OpOp32: begin
        if (funct7 == 7'd1) fVec[ClsMul] = 1'b1;
        else if (funct3 == 3'b001 || funct3 == 3'b101) fVec[ClsShift] = 1'b1;
        else fVec[ClsAlu] = 1'b1;
      end
      OpLui, OpAuipc: fVec[ClsAlu] = 1'b1;
      OpBranch: fVec[ClsJump] = 1'b1;
      OpJal: begin
        fVec[ClsJump] = 1'b1;
        fLnk          = isLinkReg(rd);
      end
      OpJalr: begin
        fVec[ClsJump]  = 1'b1;
        fVec[ClsIndir] = 1'b1;
        fLnk           = isLinkReg(rd);
        fRet           = (rd == 5'd0) && isLinkReg(rs1);
      end
      OpOpFp, OpMadd, OpMsub, OpNmsub, OpNmadd: fVec[ClsFpu] = 1'b1;
      OpSystem, OpMiscMem: fVec[ClsSys] = 1'b1;
      OpAmo: fVec[ClsAmo] = 1'b1;
      default: ;
    endcase
  end

  always_comb begin : mergeSize
    baseVec = isCompressed ? cVec : fVec;
    nextLnk = isCompressed ? cLnk : fLnk;
    nextRet = isCompressed ? cRet : fRet;
    nextVec = baseVec;
    nextVec[ClsPos0]    = pos0;
    nextVec[ClsIllegal] = (instr[15:0] == 16'd0) || (baseVec == '0);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) clsValid <= 1'b0;
    else clsValid <= instrValid;
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      clsVec   <= nextVec;
      isLnk    <= nextLnk;
      isRet    <= nextRet;
      lnk2     <= !nextLnk ? LnkNone : (isCompressed ? LnkPlus2 : LnkPlus4);
      instrOut <= instr;   // Travels alongside the class to the RAS stage.
    end
  end

endmodule

// ==== hdl/rvPredecPkg.sv ====
package rvPredecPkg;

  // Bit positions inside the class vector.
  typedef enum int unsigned {
    ClsAlu     = 0,
    ClsShift   = 1,
    ClsMul     = 2,
    ClsLoad    = 3,
    ClsStore   = 4,
    ClsLoadFpu = 5,
    ClsJump    = 6,
    ClsIndir   = 7,
    ClsFpu     = 8,
    ClsSys     = 9,
    ClsAmo     = 10,
    ClsPos0    = 11,
    ClsIllegal = 12
  } predecClassE;

  typedef enum logic [1:0] {
    LnkNone  = 2'd0,   // Not a call.
    LnkPlus2 = 2'd1,   // Compressed call.
    LnkPlus4 = 2'd2    // Full-size call.
  } lnkE;

  // ~~~~~~~~~~~~~~~~~~~~~~ Major opcodes ~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [6:0] OpLoad    = 7'b0000011;
  localparam logic [6:0] OpLoadFp  = 7'b0000111;
  localparam logic [6:0] OpMiscMem = 7'b0001111;
  localparam logic [6:0] OpImm     = 7'b0010011;
  localparam logic [6:0] OpAuipc   = 7'b0010111;
  localparam logic [6:0] OpImm32   = 7'b0011011;
  localparam logic [6:0] OpStore   = 7'b0100011;
  localparam logic [6:0] OpStoreFp = 7'b0100111;
  localparam logic [6:0] OpAmo     = 7'b0101111;
  localparam logic [6:0] OpOp      = 7'b0110011;
  localparam logic [6:0] OpLui     = 7'b0110111;
  localparam logic [6:0] OpOp32    = 7'b0111011;
  localparam logic [6:0] OpMadd    = 7'b1000011;
  localparam logic [6:0] OpMsub    = 7'b1000111;
  localparam logic [6:0] OpNmsub   = 7'b1001011;
  localparam logic [6:0] OpNmadd   = 7'b1001111;
  localparam logic [6:0] OpOpFp    = 7'b1010011;
  localparam logic [6:0] OpBranch  = 7'b1100011;
  localparam logic [6:0] OpJalr    = 7'b1100111;
  localparam logic [6:0] OpJal     = 7'b1101111;
  localparam logic [6:0] OpSystem  = 7'b1110011;

endpackage

// ==== hdl/rvPredecTop.sv ====
`include "rvPredec_params.svh"

module rvPredecTop (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  flush,
  input  logic [31:0]                           fetchWord,
  input  logic                                  fetchValid,
  output logic                                  fetchHold,
  output logic                                  outValid,
  output logic [31:0]                           outInstr,
  output logic [`RVP_CLASS_W-1:0]               outClass,
  output rvPredecPkg::lnkE                      outLnk2,
  output logic                                  rasPush,
  output logic                                  rasPop,
  output logic                                  rasHit,
  output logic [$clog2(`RVP_RAS_DEPTH + 1)-1:0] rasDepth
);
  import rvPredecPkg::*;

  // Aligner to classifier.
  logic [31:0] instr;
  logic        instrValid;
  logic        isCompressed;
  logic        pos0;

  // Classifier to RAS stage.
  logic                    clsValid;
  logic [`RVP_CLASS_W-1:0] clsVec;
  logic                    isLnk;
  logic                    isRet;
  lnkE                     lnk2;
  logic [31:0]             clsInstr;

  rvParcelAlign align0 (
    .clk(clk), .rst(rst), .flush(flush),
    .fetchWord(fetchWord), .fetchValid(fetchValid), .fetchHold(fetchHold),
    .instr(instr), .instrValid(instrValid),
    .isCompressed(isCompressed), .pos0(pos0)
  );

  rvPredecClass class0 (
    .clk(clk), .rst(rst), .flush(flush),
    .instr(instr), .instrValid(instrValid),
    .isCompressed(isCompressed), .pos0(pos0),
    .clsValid(clsValid), .clsVec(clsVec), .isLnk(isLnk), .isRet(isRet),
    .lnk2(lnk2), .instrOut(clsInstr)
  );

  rvRasHint ras0 (
    .clk(clk), .rst(rst),
    .clsValid(clsValid), .clsVec(clsVec), .isLnk(isLnk), .isRet(isRet),
    .lnk2(lnk2), .instrIn(clsInstr),
    .outValid(outValid), .outInstr(outInstr), .outClass(outClass),
    .outLnk2(outLnk2), .rasPush(rasPush), .rasPop(rasPop),
    .rasHit(rasHit), .rasDepth(rasDepth)
  );

endmodule

// ==== hdl/rvPredec_params.svh ====
`ifndef RVPREDEC_PARAMS_SVH
`define RVPREDEC_PARAMS_SVH

// Number of bits in the class vector, one per predecClassE entry.
`define RVP_CLASS_W 13

// Entries in the return-address stack.
// The depth counter saturates at this value and needs at least 2.
`define RVP_RAS_DEPTH 8

`endif

// ==== hdl/rvRasHint.sv ====
`include "rvPredec_params.svh"

module rvRasHint (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    clsValid,
  input  logic [`RVP_CLASS_W-1:0]                 clsVec,
  input  logic                                    isLnk,
  input  logic                                    isRet,
  input  rvPredecPkg::lnkE                        lnk2,
  input  logic [31:0]                             instrIn,
  output logic                                    outValid,
  output logic [31:0]                             outInstr,
  output logic [`RVP_CLASS_W-1:0]                 outClass,
  output rvPredecPkg::lnkE                        outLnk2,
  output logic                                    rasPush,
  output logic                                    rasPop,
  output logic                                    rasHit,
  output logic [$clog2(`RVP_RAS_DEPTH + 1)-1:0]   rasDepth
);

  localparam int DepthW = $clog2(`RVP_RAS_DEPTH + 1);
  localparam logic [DepthW-1:0] MaxDepth = DepthW'(`RVP_RAS_DEPTH);

  logic              doPush;
  logic              doPop;
  logic [DepthW-1:0] popDepth;
  logic [DepthW-1:0] nextDepth;

  assign doPush = clsValid && isLnk;
  assign doPop  = clsValid && isRet;

  // Pop first, then push. An instruction that does both leaves the depth alone.
  assign popDepth  = (doPop && rasDepth != '0) ? rasDepth - 1'b1 : rasDepth;
  assign nextDepth = (doPush && popDepth != MaxDepth) ? popDepth + 1'b1 : popDepth;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      rasPush  <= 1'b0;
      rasPop   <= 1'b0;
      rasHit   <= 1'b0;
      rasDepth <= '0;
    end else begin
      outValid <= clsValid;
      rasPush  <= doPush;
      rasPop   <= doPop;
      rasHit   <= doPop && (rasDepth != '0);   // The stack had a target for it.
      rasDepth <= nextDepth;
    end
  end

  always_ff @(posedge clk) begin
    if (clsValid) begin
      outInstr <= instrIn;
      outClass <= clsVec;
      outLnk2  <= lnk2;
    end
  end

endmodule

// ==== rvPredec.f ====
+incdir+hdl
hdl/rvPredecPkg.sv
hdl/rvParcelAlign.sv
hdl/rvPredecClass.sv
hdl/rvRasHint.sv
hdl/rvPredecTop.sv
verification/rvPredecChecker.sv
verification/rvPredecTb.sv

// ==== verification/rvPredecChecker.sv ====
`include "rvPredec_params.svh"

module rvPredecChecker (
  input logic                                  clk,
  input logic                                  rst,
  input logic                                  flush,
  input logic [31:0]                           fetchWord,
  input logic                                  fetchValid,
  input logic                                  fetchHold,
  input logic                                  outValid,
  input logic [31:0]                           outInstr,
  input logic [`RVP_CLASS_W-1:0]               outClass,
  input logic [1:0]                            outLnk2,
  input logic                                  rasPush,
  input logic                                  rasPop,
  input logic                                  rasHit,
  input logic [$clog2(`RVP_RAS_DEPTH + 1)-1:0] rasDepth
);
  timeunit 1ns;
  timeprecision 100ps;
  import rvPredecPkg::*;

  logic [16:0] parcels[$];   // Bit 16 marks a parcel taken from a low half.
  logic [31:0] expInstr[$];
  logic [`RVP_CLASS_W-1:0] expClass[$];
  logic [1:0]  expLnk2[$];
  logic [2:0]  expStrobe[$];  // Push, pop and hit.
  int          expDepth[$];

  int depth = 0;
  int errCount = 0;
  int outCount = 0;
  int expCount = 0;
  logic [`RVP_CLASS_W-1:0] seenClass = '0;
  bit satTop = 0;
  bit satBot = 0;
  bit rstD = 0;

  function automatic bit linkReg(input logic [4:0] r);
    return r == 5'd1 || r == 5'd5;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~ Reference class model ~~~~~~~~~~~~~~~~~~~~
  function automatic void classify(input logic [31:0] ins, input bit comp, input bit p0,
                                   output logic [`RVP_CLASS_W-1:0] v, output bit lnk,
                                   output bit ret);
    logic [6:0] op;
    logic [2:0] f3;
    bit         shiftF3;
    v = '0;
    lnk = 0;
    ret = 0;
    op = ins[6:0];
    f3 = ins[14:12];
    shiftF3 = (f3 == 3'd1) || (f3 == 3'd5);
    if (comp) begin
      case ({ins[1:0], ins[15:13]})
        5'b00_000: v[ClsAlu] = ins[12:5] != 8'd0;  // c.addi4spn with a zero immediate is illegal.
        5'b00_001, 5'b10_001: begin
          v[ClsLoad] = 1;
          v[ClsLoadFpu] = 1;
        end
        5'b00_010, 5'b00_011, 5'b10_010, 5'b10_011: v[ClsLoad] = 1;
        5'b00_101, 5'b00_110, 5'b00_111, 5'b10_101, 5'b10_110, 5'b10_111: v[ClsStore] = 1;
        5'b01_000, 5'b01_001, 5'b01_010, 5'b01_011: v[ClsAlu] = 1;
        5'b01_100: if (ins[11]) v[ClsAlu] = 1; else v[ClsShift] = 1;
        5'b01_101, 5'b01_110, 5'b01_111: v[ClsJump] = 1;
        5'b10_000: v[ClsShift] = 1;
        5'b10_100: begin
          if (ins[6:2] != 5'd0) v[ClsAlu] = 1;
          else if (ins[12] && ins[11:7] == 5'd0) v[ClsSys] = 1;
          else if (ins[11:7] != 5'd0) begin
            v[ClsJump] = 1;
            v[ClsIndir] = 1;
            lnk = ins[12];
            ret = !ins[12] && linkReg(ins[11:7]);
          end
        end
        default: ;
      endcase
    end else begin
      if (op == OpLoad || op == OpLoadFp) v[ClsLoad] = 1;
      if (op == OpLoadFp) v[ClsLoadFpu] = 1;
      if (op == OpStore || op == OpStoreFp) v[ClsStore] = 1;
      if (op == OpImm || op == OpImm32) v[shiftF3 ? ClsShift : ClsAlu] = 1;
      if (op == OpOp || op == OpOp32) begin
        if (ins[31:25] == 7'd1) v[ClsMul] = 1;
        else v[shiftF3 ? ClsShift : ClsAlu] = 1;
      end
      if (op == OpLui || op == OpAuipc) v[ClsAlu] = 1;
      if (op == OpBranch || op == OpJal || op == OpJalr) v[ClsJump] = 1;
      if (op == OpJalr) v[ClsIndir] = 1;
      if (op == OpJal || op == OpJalr) lnk = linkReg(ins[11:7]);
      if (op == OpJalr) ret = ins[11:7] == 5'd0 && linkReg(ins[19:15]);
      if (op == OpOpFp || op == OpMadd || op == OpMsub || op == OpNmsub || op == OpNmadd)
        v[ClsFpu] = 1;
      if (op == OpSystem || op == OpMiscMem) v[ClsSys] = 1;
      if (op == OpAmo) v[ClsAmo] = 1;
    end
    if (v == '0 || ins[15:0] == 16'd0) v[ClsIllegal] = 1;
    v[ClsPos0] = p0;
  endfunction

  task automatic noteInstr(input logic [31:0] ins, input bit comp, input bit p0);
    logic [`RVP_CLASS_W-1:0] v;
    bit lnk;
    bit ret;
    bit hit;
    lnkE code;
    classify(ins, comp, p0, v, lnk, ret);
    hit = ret && depth != 0;
    if (ret && depth == 0) satBot = 1;
    if (ret && depth != 0) depth--;
    if (lnk && depth == `RVP_RAS_DEPTH) satTop = 1;
    if (lnk && depth != `RVP_RAS_DEPTH) depth++;
    // A call links past its own size.
    if (!lnk) code = LnkNone;
    else if (comp) code = LnkPlus2;
    else code = LnkPlus4;
    expInstr.push_back(ins);
    expClass.push_back(v);
    expLnk2.push_back(code);
    expStrobe.push_back({lnk, ret, hit});
    expDepth.push_back(depth);
    expCount++;
  endtask

  // Splits the buffered parcels into whole instructions.
  task automatic extract();
    while (parcels.size() > 0) begin
      if (parcels[0][1:0] != 2'b11) begin
        noteInstr({16'd0, parcels[0][15:0]}, 1, parcels[0][16]);
        void'(parcels.pop_front());
      end else if (parcels.size() >= 2) begin
        noteInstr({parcels[1][15:0], parcels[0][15:0]}, 0, parcels[0][16]);
        void'(parcels.pop_front());
        void'(parcels.pop_front());
      end else begin
        break;
      end
    end
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      errCount++;
      $display("Mismatch %s expected %h got %h", name, exp, got);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~ Port monitor ~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (rstD && (outValid !== 1'b0 || fetchHold !== 1'b0 || rasPush !== 1'b0 ||
                 rasPop !== 1'b0 || rasDepth !== '0)) begin
      errCount++;
      $display("Outputs left their reset values while reset was applied");
    end
    if (rst) begin
      parcels.delete();
      depth = 0;
    end else if (flush) begin
      parcels.delete();   // Pending parcels and unfinished instructions are dropped.
    end else if (fetchValid && !fetchHold) begin
      parcels.push_back({1'b1, fetchWord[15:0]});
      parcels.push_back({1'b0, fetchWord[31:16]});
      extract();
    end
    if (!rstD && outValid === 1'b1) begin
      outCount++;
      seenClass |= outClass;
      if (expInstr.size() == 0) begin
        errCount++;
        $display("DUT produced an instruction that the model did not expect");
      end else begin
        compare("outInstr", expInstr.pop_front(), outInstr);
        compare("outClass", 32'(expClass.pop_front()), 32'(outClass));
        compare("outLnk2", 32'(expLnk2.pop_front()), 32'(outLnk2));
        compare("rasPush", 32'(expStrobe[0][2]), 32'(rasPush));
        compare("rasPop", 32'(expStrobe[0][1]), 32'(rasPop));
        compare("rasHit", 32'(expStrobe[0][0]), 32'(rasHit));
        void'(expStrobe.pop_front());
        compare("rasDepth", 32'(expDepth.pop_front()), 32'(rasDepth));
      end
    end
    rstD <= rst;
  end

endmodule

// ==== verification/rvPredecTb.sv ====
`include "rvPredec_params.svh"

module rvPredecTb;
  timeunit 1ns;
  timeprecision 100ps;
  import rvPredecPkg::*;

  logic        clk;
  logic        rst;
  logic        flush;
  logic [31:0] fetchWord;
  logic        fetchValid;
  logic        fetchHold;
  logic        outValid;
  logic [31:0] outInstr;
  logic [`RVP_CLASS_W-1:0] outClass;
  lnkE         outLnk2;
  logic        rasPush;
  logic        rasPop;
  logic        rasHit;
  logic [$clog2(`RVP_RAS_DEPTH + 1)-1:0] rasDepth;

  logic [15:0] hwQ[$];
  int cycleCount = 0;
  int cycleLimit = 200;   // Grows with each test's word count.
  int tbErrors = 0;
  int testNo = 0;
  int lastErr = 0;
  int lastOut = 0;

  rvPredecTop dut0 (.*);
  rvPredecChecker chk0 (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: pipeline stopped producing instructions");
      $display("TB FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Instruction templates ~~~~~~~~~~~~~~~~~~~~
  // Bit 32 of the result flags a compressed instruction.
  function automatic logic [32:0] makeInstr(input int kind);
    logic [24:0] u;
    logic [4:0]  rs;
    u = 25'($urandom);
    rs = 5'($urandom % 31 + 1);   // Never x0.
    case (kind)
      0: return {17'h10000, 3'b000, u[10:0], 2'b01};          // c.addi
      1: return {17'h10000, 3'b100, u[10], 2'b00, u[7:0], 2'b01};  // c.srli
      2: return {17'h10000, 3'b100, u[10], 2'b10, u[7:0], 2'b01};  // c.andi
      3: return {17'h10000, 3'b010, u[10:0], 2'b00};          // c.lw
      4: return {17'h10000, 3'b001, u[10:0], 2'b00};          // c.fld
      5: return {17'h10000, 3'b110, u[10:0], 2'b00};          // c.sw
      6: return {17'h10000, 3'b101, u[10:0], 2'b01};          // c.j
      7: return {17'h10000, 3'b000, u[10:0], 2'b10};          // c.slli
      8: return {17'h10000, 4'b1000, rs, 5'd0, 2'b10};        // c.jr
      9: return {17'h10000, 4'b1001, rs, 5'd0, 2'b10};        // c.jalr
      10: return {17'h10000, 4'b1000, u[4:0], rs, 2'b10};     // c.mv
      11: return {17'h10000, 16'h9002};                       // c.ebreak
      12: return {17'h10000, 16'h0000};
      13: return {1'b0, u, OpImm};
      14: return {1'b0, u, OpImm32};
      15: return {1'b0, u, OpOp};
      16: return {1'b0, 7'd1, u[17:0], OpOp32};
      17: return {1'b0, u, OpLoad};
      18: return {1'b0, u, OpLoadFp};
      19: return {1'b0, u, OpStore};
      20: return {1'b0, u, OpBranch};
      21: return {1'b0, u, OpJal};
      22: return {1'b0, u, OpJalr};
      23: return {1'b0, u, OpOpFp};
      24: return {1'b0, u, OpMadd};
      25: return {1'b0, u, OpSystem};
      26: return {1'b0, u, OpMiscMem};
      27: return {1'b0, u, OpAmo};
      28: return {1'b0, u, OpLui};
      29: return {1'b0, u, OpAuipc};
      30: return {1'b0, u[24:5], 5'd1, OpJal};                // Full call.
      31: return {17'h10000, 4'b1001, 5'd5, 5'd0, 2'b10};     // Compressed call.
      32: return {1'b0, u[24:13], 5'd1, 3'b000, 5'd0, OpJalr}; // Full return.
      default: return {17'h10000, 4'b1000, 5'd1, 5'd0, 2'b10}; // Compressed return.
    endcase
  endfunction

  task automatic queueInstr(input int kind);
    logic [32:0] v;
    v = makeInstr(kind);
    hwQ.push_back(v[15:0]);
    if (!v[32]) hwQ.push_back(v[31:16]);
  endtask

  // Entered 1 ns after an edge. Holds the word until the aligner takes it.
  task automatic sendWord(input logic [31:0] w);
    bit taken;
    if ($urandom % 4 == 0) begin
      fetchValid = 0;
      @(posedge clk);
      #1;
    end
    fetchWord = w;
    fetchValid = 1;
    do begin
      taken = !fetchHold;
      @(posedge clk);
      #1;
    end while (!taken);
    fetchValid = 0;
  endtask

  task automatic sendQueue();
    if (hwQ.size() % 2 != 0) hwQ.push_back(16'h0001);   // c.nop fills the last word.
    cycleLimit += hwQ.size() / 2 * 4;
    while (hwQ.size() > 0) begin
      sendWord({hwQ[1], hwQ[0]});
      void'(hwQ.pop_front());
      void'(hwQ.pop_front());
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic buildStream(input int mode, input int count);
    for (int i = 0; i < count; i++) begin
      if (mode == 0) queueInstr($urandom % 13);
      else if (mode == 1) queueInstr($urandom % 30);
      else if ($urandom % 3 == 0) queueInstr($urandom % 30);
      else if (i < count / 2) queueInstr(30 + $urandom % 2);
      else queueInstr(32 + $urandom % 2);
    end
  endtask

  task automatic endTest(input string name);
    testNo++;
    $display("Test %0d %s finished: %0d instructions, %0d errors", testNo, name,
             chk0.outCount - lastOut, chk0.errCount + tbErrors - lastErr);
    lastErr = chk0.errCount + tbErrors;
    lastOut = chk0.outCount;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~ Test sequence ~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [32:0] full;
    clk = 0;
    rst = 1;
    flush = 0;
    fetchValid = 0;
    fetchWord = '0;
    void'($urandom(32'h77cb));
    repeat (10) @(posedge clk);
    #1 rst = 0;
    @(posedge clk);
    #1;
    endTest("reset state");
    buildStream(0, 60);
    sendQueue();
    endTest("compressed stream");
    buildStream(1, 120);
    sendQueue();
    endTest("mixed stream");
    for (int k = 0; k < 34; k++) queueInstr(k);
    sendQueue();
    endTest("class coverage");
    buildStream(2, 60);
    sendQueue();
    if (!chk0.satTop || !chk0.satBot) begin
      tbErrors++;
      $display("Return stack depth never saturated at both ends");
    end
    endTest("call and return");
    buildStream(2, 20);
    // Calls leave the stack non-empty across the flush.
    for (int k = 0; k < 3; k++) queueInstr(30);
    sendQueue();
    full = makeInstr(13);
    sendWord({full[15:0], 16'h0001});   // Leaves half of a full instruction buffered.
    repeat (6) @(posedge clk);
    #1;
    flush = 1;
    fetchValid = 1;
    fetchWord = $urandom;
    @(posedge clk);
    #1;
    flush = 0;
    fetchValid = 0;
    buildStream(1, 30);
    sendQueue();
    endTest("flush");
    if (chk0.seenClass != '1) begin
      tbErrors++;
      $display("Not every class bit was seen, coverage %h", chk0.seenClass);
    end
    if (chk0.outCount != chk0.expCount) begin
      tbErrors++;
      $display("DUT gave %0d instructions but the model expected %0d", chk0.outCount,
               chk0.expCount);
    end
    $display("Tests %0d, instructions %0d, errors %0d", testNo, chk0.outCount,
             chk0.errCount + tbErrors);
    if (chk0.errCount + tbErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
